/* build.f */
design/vdp_pkg.sv
design/vram.sv
design/vram_rd_demux.sv
design/vdp_cpu_port.sv
design/vdp_vram_top.sv
dv/vdp_vram_tb.sv

/* Bender.yml */
package:
  name: vdp_vram

sources:
  - design/vdp_pkg.sv
  - design/vram.sv
  - design/vram_rd_demux.sv
  - design/vdp_cpu_port.sv
  - design/vdp_vram_top.sv
  - target: test
    files:
      - dv/vdp_vram_tb.sv

/* dv/vdp_vram_tb.sv */
`timescale 1ns/100ps

module vdp_vram_tb
    import vdp_pkg::*;
();

    // Fixed seed, wait limit per transfer and length of the random mix
    localparam logic [31:0] SEED           = 32'h1d40;
    localparam int          TIMEOUT_CYCLES = 50;
    localparam int          NUM_RANDOM_OPS = 400;

    logic      clk = 1'b0;
    logic      reset;
    apb_req_t  apb_req;
    apb_rsp_t  apb_rsp;
    vdp_regs_t regs;

    int        check_count    = 0;
    int        mismatch_count = 0;
    int        timeout_count  = 0;
    string     test_name      = "reset";

    // Completed reads waiting for the checker
    vdp_byte_t exp_q[$];
    vdp_byte_t act_q[$];
    string     name_q[$];

    // ****************************************
    // Reference model state
    // ****************************************

    vdp_byte_t  m_mem [VRAM_DEPTH];
    vram_addr_t m_addr    = '0;
    logic       m_toggle  = 1'b0;
    vdp_byte_t  m_pending = '0;
    vdp_byte_t  m_latch   = '0;
    vdp_regs_t  m_regs    = '0;

    vdp_vram_top u_vdp_vram_top (
        .clk     (clk),
        .reset   (reset),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .regs    (regs)
    );

    // 8 ns period
    always #4 clk = ~clk;

    // Applies one host access to the model and returns what a read should see
    function automatic vdp_byte_t model_apply(input logic write, input logic port,
                                              input vdp_byte_t wdata);
        vdp_byte_t  result;
        vram_addr_t setup;
        result = '0;
        setup  = {wdata[5:0], m_pending};
        if (port == APB_PORT_DATA) begin
            if (write) begin
                m_mem[m_addr] = wdata;
            end else begin
                // The read returns the old latch, then prefetches the current address
                result  = m_latch;
                m_latch = m_mem[m_addr];
            end
            m_addr = m_addr + 1'b1;
        end else if (!write) begin
            m_toggle = 1'b0;
        end else if (!m_toggle) begin
            m_pending = wdata;
            m_toggle  = 1'b1;
        end else begin
            m_toggle = 1'b0;
            if (wdata[7]) begin
                m_regs[wdata[2:0]] = m_pending;
            end else if (wdata[6]) begin
                m_addr = setup;
            end else begin
                m_latch = m_mem[setup];
                m_addr  = setup + 1'b1;
            end
        end
        return result;
    endfunction

    // ****************************************
    // Compare tasks
    // ****************************************

    task automatic check_byte(input string name, input vdp_byte_t expected,
                              input vdp_byte_t actual);
        check_count++;
        if (actual !== expected) begin
            mismatch_count++;
            $display("mismatch %s expected %02h actual %02h", name, expected, actual);
        end
    endtask

    task automatic check_regs(input string name, input vdp_regs_t expected,
                              input vdp_regs_t actual);
        check_count++;
        if (actual !== expected) begin
            mismatch_count++;
            $display("mismatch %s expected %016h actual %016h", name, expected, actual);
        end
    endtask

    // Drains the completed reads once per cycle
    always @(negedge clk) begin
        while (act_q.size() != 0) begin
            check_byte(name_q.pop_front(), exp_q.pop_front(), act_q.pop_front());
        end
    end

    // ****************************************
    // APB driver
    // ****************************************

    // Entered and left 1 ns after a rising edge
    task automatic apb_transfer(input logic write, input logic port, input vdp_byte_t wdata,
                                output vdp_byte_t rdata);
        int waits;
        waits           = 0;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = port;
        apb_req.pwdata  = wdata;
        @(posedge clk);
        #1;
        apb_req.penable = 1'b1;
        // pready and prdata are looked at mid-cycle, away from the edge
        @(negedge clk);
        while (!apb_rsp.pready && waits < TIMEOUT_CYCLES) begin
            waits++;
            @(negedge clk);
        end
        if (!apb_rsp.pready) begin
            timeout_count++;
            $display("%s: pready never rose within %0d cycles", test_name, TIMEOUT_CYCLES);
        end
        rdata = apb_rsp.prdata;
        @(posedge clk);
        #1;
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    task automatic apb_write(input logic port, input vdp_byte_t wdata);
        vdp_byte_t unused;
        void'(model_apply(1'b1, port, wdata));
        apb_transfer(1'b1, port, wdata, unused);
    endtask

    // Queues the model's expected byte next to what the DUT returned
    task automatic apb_read(input logic port);
        vdp_byte_t expected;
        vdp_byte_t actual;
        expected = model_apply(1'b0, port, '0);
        apb_transfer(1'b0, port, '0, actual);
        exp_q.push_back(expected);
        act_q.push_back(actual);
        name_q.push_back(test_name);
    endtask

    task automatic set_write_addr(input vram_addr_t addr);
        apb_write(APB_PORT_CTRL, addr[7:0]);
        apb_write(APB_PORT_CTRL, {2'b01, addr[13:8]});
    endtask

    task automatic set_read_addr(input vram_addr_t addr);
        apb_write(APB_PORT_CTRL, addr[7:0]);
        apb_write(APB_PORT_CTRL, {2'b00, addr[13:8]});
    endtask

    // The register bank updates on the completing edge, so it is checked right away
    task automatic write_reg(input vdp_reg_sel_t sel, input vdp_byte_t value);
        apb_write(APB_PORT_CTRL, value);
        apb_write(APB_PORT_CTRL, {5'b10000, sel});
        check_regs(test_name, m_regs, regs);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // ****************************************
    // Tests
    // ****************************************

    initial begin : run_tests
        int         kind;
        vram_addr_t addr;
        void'($urandom(SEED));
        reset   = 1'b1;
        apb_req = '0;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        check_regs(test_name, m_regs, regs);

        // The RAM powers up unknown, so give every byte a known value first
        test_name = "fill";
        set_write_addr('0);
        for (int i = 0; i < VRAM_DEPTH; i++) begin
            apb_write(APB_PORT_DATA, i[7:0] ^ {2'b10, i[13:8]});
        end

        test_name = "register_writes";
        for (int r = 0; r < VDP_NUM_REGS; r++) begin
            write_reg(r[2:0], 8'h5a ^ (r[7:0] * 8'h1f));
        end

        // Auto-increment on both the write and the read side
        test_name = "write_read_back";
        set_write_addr(14'h1230);
        for (int i = 0; i < 16; i++) begin
            apb_write(APB_PORT_DATA, $urandom_range(0, 255));
        end
        set_read_addr(14'h1230);
        for (int i = 0; i < 16; i++) begin
            apb_read(APB_PORT_DATA);
        end

        // A write between two reads leaves the prefetched byte alone
        test_name = "read_ahead_order";
        set_read_addr(14'h2000);
        apb_read(APB_PORT_DATA);
        apb_write(APB_PORT_DATA, 8'hc3);
        apb_read(APB_PORT_DATA);
        apb_read(APB_PORT_DATA);

        test_name = "toggle_reset";
        apb_write(APB_PORT_CTRL, 8'h34);
        apb_read(APB_PORT_CTRL);
        set_write_addr(14'h0abc);
        for (int i = 0; i < 4; i++) begin
            apb_write(APB_PORT_DATA, 8'h70 + i[7:0]);
        end
        set_read_addr(14'h0abc);
        for (int i = 0; i < 4; i++) begin
            apb_read(APB_PORT_DATA);
        end

        test_name = "address_wrap";
        set_write_addr(14'h3fff);
        apb_write(APB_PORT_DATA, 8'he1);
        apb_write(APB_PORT_DATA, 8'h1e);
        set_read_addr(14'h3fff);
        apb_read(APB_PORT_DATA);
        apb_read(APB_PORT_DATA);

        test_name = "random_mix";
        for (int n = 0; n < NUM_RANDOM_OPS; n++) begin
            kind = $urandom_range(0, 6);
            addr = $urandom_range(0, VRAM_DEPTH - 1);
            case (kind)
                0: write_reg($urandom_range(0, 7), $urandom_range(0, 255));
                1: set_write_addr(addr);
                2: set_read_addr(addr);
                3: apb_write(APB_PORT_DATA, $urandom_range(0, 255));
                4: apb_read(APB_PORT_CTRL);
                default: apb_read(APB_PORT_DATA);
            endcase
            idle_cycles($urandom_range(0, 3));
        end
        check_regs(test_name, m_regs, regs);

        // Let the checker drain the last reads
        repeat (2) @(negedge clk);
        $display("checks %0d mismatches %0d timeouts %0d",
                 check_count, mismatch_count, timeout_count);
        if (mismatch_count == 0 && timeout_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* design/vdp_vram_top.sv */
`timescale 1ns/100ps

module vdp_vram_top
    import vdp_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  apb_req_t  apb_req,
    output apb_rsp_t  apb_rsp,
    output vdp_regs_t regs
);

    // ****************************************
    // Internal paths
    // ****************************************

    // Request from the host port to the RAM
    vram_req_t vram_req;

    // Marks a read request, for the delayed capture
    logic      rd_tick;

    // Registered RAM output
    vdp_byte_t vram_rdata;

    // Read-ahead byte returned to the host port
    vdp_byte_t read_latch;

    // ****************************************
    // Instances
    // ****************************************

    // APB decode, address counter, register bank and request generation
    vdp_cpu_port u_cpu_port (
        .clk        (clk),
        .reset      (reset),
        .apb_req    (apb_req),
        .apb_rsp    (apb_rsp),
        .vram_req   (vram_req),
        .rd_tick    (rd_tick),
        .read_latch (read_latch),
        .regs       (regs)
    );

    // The CPU port is the only client, so no arbiter sits in front
    vram u_vram (
        .clk      (clk),
        .vram_req (vram_req),
        .rdata    (vram_rdata)
    );

    // Loads the read-ahead latch one clock after the RAM has registered its byte
    vram_rd_demux u_rd_demux (
        .clk     (clk),
        .reset   (reset),
        .rd_tick (rd_tick),
        .din     (vram_rdata),
        .dout    (read_latch)
    );

endmodule

/* design/vdp_cpu_port.sv */
`timescale 1ns/100ps

module vdp_cpu_port
    import vdp_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  apb_req_t  apb_req,
    output apb_rsp_t  apb_rsp,
    output vram_req_t vram_req,
    output logic      rd_tick,
    input  vdp_byte_t read_latch,
    output vdp_regs_t regs
);

    // ****************************************
    // State
    // ****************************************

    // Read-ahead tracker, busy from the request until the latch is loaded
    fetch_state_t fetch_state;

    // Current VRAM address, auto-incremented by data accesses
    vram_addr_t   addr_q;

    // Set after the first control byte, cleared by the second one
    logic         toggle_q;

    // First control byte, held until the command byte arrives
    vdp_byte_t    pending_q;

    // Control register bank
    vdp_regs_t    regs_q;

    // Registered RAM request and its read marker
    vram_req_t    vram_req_q;
    logic         rd_tick_q;

    // ****************************************
    // Transfer decode
    // ****************************************

    logic         ready;
    logic         xfer_done;
    logic         data_wr;
    logic         data_rd;
    logic         ctrl_wr;
    logic         ctrl_rd;
    logic         cmd_byte;
    logic         rd_setup;
    logic         wr_setup;
    logic         reg_wr;
    logic         issue_read;
    vram_addr_t   setup_addr;
    vram_addr_t   access_addr;
    vdp_reg_sel_t reg_sel;

    // Wait states only while a read-ahead is still on its way to the latch
    assign ready     = (fetch_state == FETCH_IDLE);

    // A transfer takes effect on the edge where the access cycle meets pready
    assign xfer_done = apb_req.psel && apb_req.penable && ready;

    assign data_wr = xfer_done && apb_req.pwrite && (apb_req.paddr == APB_PORT_DATA);
    assign data_rd = xfer_done && !apb_req.pwrite && (apb_req.paddr == APB_PORT_DATA);
    assign ctrl_wr = xfer_done && apb_req.pwrite && (apb_req.paddr == APB_PORT_CTRL);
    assign ctrl_rd = xfer_done && !apb_req.pwrite && (apb_req.paddr == APB_PORT_CTRL);

    // The second control byte carries the command in its top two bits
    assign cmd_byte = ctrl_wr && toggle_q;
    assign rd_setup = cmd_byte && (apb_req.pwdata[7:6] == 2'b00);
    assign wr_setup = cmd_byte && (apb_req.pwdata[7:6] == 2'b01);
    assign reg_wr   = cmd_byte && apb_req.pwdata[7];

    // Six high address bits come with the command, eight low bits were pending
    assign setup_addr = {apb_req.pwdata[5:0], pending_q};

    // A read setup fetches from the address it has just loaded
    assign access_addr = rd_setup ? setup_addr : addr_q;

    // Data reads and read setups both start a read-ahead
    assign issue_read = data_rd || rd_setup;

    // Register number sits in the low bits of the command byte
    assign reg_sel = apb_req.pwdata[VDP_REG_SEL_W-1:0];

    // ****************************************
    // Address and byte toggle
    // ****************************************

    // Every access moves the address on by one, wrapping at the top of VRAM.
    // A write setup only loads it
    always_ff @(posedge clk) begin
        if (reset) begin
            addr_q <= '0;
        end else if (issue_read || data_wr) begin
            addr_q <= access_addr + 1'b1;
        end else if (wr_setup) begin
            addr_q <= setup_addr;
        end
    end

    // A control read puts the toggle back on the first byte,
    // which lets the host resynchronise after a lost byte
    always_ff @(posedge clk) begin
        if (reset) begin
            toggle_q  <= 1'b0;
            pending_q <= '0;
        end else if (ctrl_rd) begin
            toggle_q <= 1'b0;
        end else if (ctrl_wr) begin
            toggle_q <= !toggle_q;
            if (!toggle_q) begin
                pending_q <= apb_req.pwdata;
            end
        end
    end

    // ****************************************
    // Register bank
    // ****************************************

    // The pending byte is the value, the command byte names the register
    always_ff @(posedge clk) begin
        if (reset) begin
            regs_q <= '0;
        end else if (reg_wr) begin
            regs_q[reg_sel] <= pending_q;
        end
    end

    // ****************************************
    // VRAM request and read-ahead tracking
    // ****************************************

    // valid and rd_tick are single-clock pulses from the completing edge
    always_ff @(posedge clk) begin
        if (reset) begin
            vram_req_q <= '0;
            rd_tick_q  <= 1'b0;
        end else begin
            vram_req_q.valid <= issue_read || data_wr;
            vram_req_q.we    <= data_wr;
            vram_req_q.addr  <= access_addr;
            vram_req_q.wdata <= apb_req.pwdata;
            rd_tick_q        <= issue_read;
        end
    end

    // ISSUED while the RAM reads, CAPTURE while the demux loads the latch
    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_state <= FETCH_IDLE;
        end else begin
            case (fetch_state)
                FETCH_IDLE: begin
                    if (issue_read) begin
                        fetch_state <= FETCH_ISSUED;
                    end
                end
                FETCH_ISSUED: begin
                    fetch_state <= FETCH_CAPTURE;
                end
                default: begin
                    fetch_state <= FETCH_IDLE;
                end
            endcase
        end
    end

    // ****************************************
    // Outputs
    // ****************************************

    // Data reads see the latch as it was before this read's own fetch.
    // Control reads return zero since status flags are not modelled
    assign apb_rsp.pready = ready;
    assign apb_rsp.prdata = (apb_req.paddr == APB_PORT_CTRL) ? '0 : read_latch;

    assign vram_req = vram_req_q;
    assign rd_tick  = rd_tick_q;
    assign regs     = regs_q;

endmodule

/* design/vram_rd_demux.sv */
`timescale 1ns/100ps

module vram_rd_demux
    import vdp_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      rd_tick,
    input  vdp_byte_t din,
    output vdp_byte_t dout
);

    // Remembers that a read was requested on the previous clock
    logic      tick_q;

    // The read-ahead latch itself
    vdp_byte_t dout_q;

    // The RAM registers its output on the edge that samples the request,
    // so the byte is only stable after that edge.
    // The flag delays the capture by one clock to line up with it
    always_ff @(posedge clk) begin
        if (reset) begin
            tick_q <= 1'b0;
            dout_q <= '0;
        end else begin
            tick_q <= rd_tick;
            if (tick_q) begin
                dout_q <= din;
            end
        end
    end

    assign dout = dout_q;

endmodule

/* design/vram.sv */
`timescale 1ns/100ps

module vram
    import vdp_pkg::*;
(
    input  logic      clk,
    input  vram_req_t vram_req,
    output vdp_byte_t rdata
);

    // ****************************************
    // Storage
    // ****************************************

    // One byte for every VRAM address
    vdp_byte_t mem [VRAM_DEPTH];

    // Register holding the last byte read out
    vdp_byte_t rdata_q;

    // A valid request either stores a byte or reads one.
    // A write leaves the read register alone, so the last read byte
    // stays on rdata until another read comes along
    always_ff @(posedge clk) begin
        if (vram_req.valid) begin
            if (vram_req.we) begin
                mem[vram_req.addr] <= vram_req.wdata;
            end else begin
                rdata_q <= mem[vram_req.addr];
            end
        end
    end

    // Registered output, one clock after the request
    assign rdata = rdata_q;

endmodule

/* design/vdp_pkg.sv */
package vdp_pkg;

    // ****************************************
    // Geometry of the video memory and register bank
    // ****************************************

    // Fourteen address bits reach every byte of the 16 KiB VRAM
    localparam int VRAM_ADDR_W   = 14;
    localparam int VRAM_DEPTH    = 16384;

    // Eight control registers, picked by a 3-bit register number
    localparam int VDP_NUM_REGS  = 8;
    localparam int VDP_REG_SEL_W = 3;

    // APB paddr selects one of the two byte-wide host ports
    localparam logic APB_PORT_DATA = 1'b0;
    localparam logic APB_PORT_CTRL = 1'b1;

    // ****************************************
    // Vector types
    // ****************************************

    typedef logic [VRAM_ADDR_W-1:0]   vram_addr_t;
    typedef logic [7:0]               vdp_byte_t;
    typedef logic [VDP_REG_SEL_W-1:0] vdp_reg_sel_t;

    // Register 0 sits in the low byte
    typedef vdp_byte_t [VDP_NUM_REGS-1:0] vdp_regs_t;

    // ****************************************
    // Bus bundles
    // ****************************************

    // Signals driven by the APB master
    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        logic      paddr;
        vdp_byte_t pwdata;
    } apb_req_t;

    // Signals driven back by the slave
    typedef struct packed {
        logic      pready;
        vdp_byte_t prdata;
    } apb_rsp_t;

    // One access to the VRAM, valid for a single clock
    typedef struct packed {
        logic       valid;
        logic       we;
        vram_addr_t addr;
        vdp_byte_t  wdata;
    } vram_req_t;

    // Progress of one read-ahead through RAM and capture stage
    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_ISSUED,
        FETCH_CAPTURE
    } fetch_state_t;

endpackage
